// ==== source/conv_pkg.sv ====
package conv_pkg;

  // Pixel and weight width.
  localparam int DWIDTH = 16;

  // Square image side and square filter side.
  localparam int IMG_SIZE = 16;
  localparam int FIL_SIZE = 3;

  // One spare line lets a row be written while the FIL_SIZE rows above it are read.
  localparam int BUF_LINES = FIL_SIZE + 1;

  localparam int ADDR_WIDTH = $clog2(IMG_SIZE);
  localparam int SEL_WIDTH  = $clog2(BUF_LINES + 1);  // Selects carry 0 to BUF_LINES.

  // Full product width plus growth for the FIL_SIZE squared term sum.
  localparam int ACC_WIDTH = 2 * DWIDTH + $clog2(FIL_SIZE * FIL_SIZE);

  typedef logic signed [DWIDTH-1:0]    pixel_t;
  typedef logic        [ADDR_WIDTH-1:0] addr_t;
  typedef logic        [SEL_WIDTH-1:0]  sel_t;
  typedef logic signed [ACC_WIDTH-1:0] acc_t;

  // Entry FIL_SIZE*i+j holds row offset i and column offset j, the oldest first.
  typedef struct packed {
    pixel_t [FIL_SIZE*FIL_SIZE-1:0] pix;
  } window_t;

  // Same indexing as the window.
  typedef struct packed {
    pixel_t [FIL_SIZE*FIL_SIZE-1:0] weight;
  } kernel_t;

  // FILL stores the first rows, SWEEP produces outputs while writing,
  // FLUSH reads the last rows once more without writing.
  typedef enum logic [1:0] {
    IDLE,
    FILL,
    SWEEP,
    FLUSH
  } ctrl_state_t;

endpackage

// ==== source/mem_sp.sv ====
`timescale 1ns/1ps

module mem_sp (
  input  logic             clk,
  input  logic             mem_we,
  input  conv_pkg::addr_t  mem_addr,
  input  conv_pkg::pixel_t mem_wdata,
  output conv_pkg::pixel_t mem_rdata
);

  // One image row of pixels.
  conv_pkg::pixel_t mem [conv_pkg::IMG_SIZE];

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr];  // Old word on a same-address write.
  end

endmodule

// ==== source/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer (
  input  logic              clk,
  input  logic              xrst,
  input  conv_pkg::sel_t    buf_wsel,
  input  conv_pkg::sel_t    buf_rsel,
  input  logic              buf_we,
  input  conv_pkg::addr_t   buf_addr,
  input  conv_pkg::pixel_t  buf_input,
  output conv_pkg::window_t buf_output
);

  conv_pkg::pixel_t  in_q;                                // Pixel aligned with the control.
  conv_pkg::sel_t    rsel_q;                              // Read select aligned with rdata.
  logic              line_we [conv_pkg::BUF_LINES];
  conv_pkg::pixel_t  line_rdata [conv_pkg::BUF_LINES];
  conv_pkg::pixel_t  col_new [conv_pkg::FIL_SIZE];        // Newest column, one pixel per row.
  conv_pkg::window_t win_q;

  // True when line wsel-1 is one of the FIL_SIZE lines read from base rsel-1.
  function automatic logic line_read(input conv_pkg::sel_t rsel, input conv_pkg::sel_t wsel);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < conv_pkg::FIL_SIZE; i++) begin
      if ((int'(rsel) - 1 + i) % conv_pkg::BUF_LINES == int'(wsel) - 1) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  always_ff @(posedge clk) begin
    if (!xrst) begin
      in_q   <= '0;
      rsel_q <= '0;
    end else begin
      in_q   <= buf_input;
      rsel_q <= buf_rsel;
    end
  end

  for (genvar k = 0; k < conv_pkg::BUF_LINES; k++) begin : g_line
    assign line_we[k] = buf_we && (buf_wsel == conv_pkg::sel_t'(k + 1));

    mem_sp u_mem (
      .clk       (clk),
      .mem_we    (line_we[k]),
      .mem_addr  (buf_addr),
      .mem_wdata (in_q),
      .mem_rdata (line_rdata[k])
    );
  end

  // Window row i takes line (base+i) mod BUF_LINES, or zero while select is 0.
  for (genvar i = 0; i < conv_pkg::FIL_SIZE; i++) begin : g_row
    conv_pkg::pixel_t mux [conv_pkg::BUF_LINES+1];

    assign mux[0] = '0;
    for (genvar k = 0; k < conv_pkg::BUF_LINES; k++) begin : g_src
      assign mux[k+1] = line_rdata[(i + k) % conv_pkg::BUF_LINES];
    end
    assign col_new[i] = mux[rsel_q];
  end

  // Each window row shifts every cycle, the new column enters at the highest offset.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      win_q <= '0;
    end else begin
      for (int i = 0; i < conv_pkg::FIL_SIZE; i++) begin
        for (int j = 0; j < conv_pkg::FIL_SIZE - 1; j++) begin
          win_q.pix[conv_pkg::FIL_SIZE*i+j] <= win_q.pix[conv_pkg::FIL_SIZE*i+j+1];
        end
        win_q.pix[conv_pkg::FIL_SIZE*i+conv_pkg::FIL_SIZE-1] <= col_new[i];
      end
    end
  end

  assign buf_output = win_q;

  // The controller must never write a line that is being read for the window.
  a_no_rw_clash: assert property (@(posedge clk) disable iff (!xrst)
    (buf_we && buf_wsel != '0 && buf_rsel != '0) |-> !line_read(buf_rsel, buf_wsel));

endmodule

// ==== source/linebuf_ctrl.sv ====
`timescale 1ns/1ps

module linebuf_ctrl (
  input  logic            clk,
  input  logic            xrst,
  input  logic            start,
  input  logic            pixel_valid,
  output conv_pkg::sel_t  buf_wsel,
  output conv_pkg::sel_t  buf_rsel,
  output logic            buf_we,
  output conv_pkg::addr_t buf_addr,
  output logic            win_valid,
  output logic            frame_done
);

  conv_pkg::ctrl_state_t state;
  conv_pkg::addr_t       col;
  conv_pkg::addr_t       row;        // Row index, same range as a column.
  conv_pkg::sel_t        wr_line;    // Line that takes the current row.
  conv_pkg::sel_t        rd_base;    // Line holding the oldest window row.
  logic                  flush_run;  // Low during the idle cycle that opens FLUSH.
  logic [2:0]            win_dly;
  logic [2:0]            end_dly;
  logic                  pix_ok;
  logic                  flush_col;
  logic                  col_last;
  logic                  row_last;
  logic                  rd_go;
  logic                  win_go;
  logic                  end_go;

  function automatic conv_pkg::sel_t next_line(input conv_pkg::sel_t line);
    if (line == conv_pkg::sel_t'(conv_pkg::BUF_LINES - 1)) begin
      return '0;
    end
    return line + 1'b1;
  endfunction

  assign pix_ok    = pixel_valid && (state == conv_pkg::FILL || state == conv_pkg::SWEEP);
  assign flush_col = (state == conv_pkg::FLUSH) && flush_run;
  assign col_last  = (col == conv_pkg::addr_t'(conv_pkg::IMG_SIZE - 1));
  assign row_last  = (row == conv_pkg::addr_t'(conv_pkg::IMG_SIZE - 1));
  assign rd_go     = (pix_ok && state == conv_pkg::SWEEP) || flush_col;
  assign win_go    = rd_go && (col >= conv_pkg::addr_t'(conv_pkg::FIL_SIZE - 1));
  assign end_go    = flush_col && col_last;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= conv_pkg::IDLE;
      col       <= '0;
      row       <= '0;
      wr_line   <= '0;
      rd_base   <= '0;
      flush_run <= 1'b0;
    end else begin
      case (state)
        conv_pkg::IDLE: begin
          if (start) begin
            state   <= conv_pkg::FILL;
            col     <= '0;
            row     <= '0;
            rd_base <= wr_line;  // Line pointers carry over from the last frame.
          end
        end
        conv_pkg::FILL, conv_pkg::SWEEP: begin
          if (pix_ok) begin
            col <= col + 1'b1;
            if (col_last) begin
              col     <= '0;
              row     <= row + 1'b1;
              wr_line <= next_line(wr_line);
              if (state == conv_pkg::SWEEP) begin
                rd_base <= next_line(rd_base);
              end
              if (row == conv_pkg::addr_t'(conv_pkg::FIL_SIZE - 1)) begin
                state <= conv_pkg::SWEEP;
              end
              if (row_last) begin
                state <= conv_pkg::FLUSH;
              end
            end
          end
        end
        conv_pkg::FLUSH: begin
          flush_run <= 1'b1;
          if (flush_run) begin
            col <= col + 1'b1;
            if (col_last) begin
              col       <= '0;
              flush_run <= 1'b0;
              state     <= conv_pkg::IDLE;
            end
          end
        end
        default: state <= conv_pkg::IDLE;
      endcase
    end
  end

  // Control is registered so it meets the registered pixel inside the line buffer.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      buf_we     <= 1'b0;
      buf_wsel   <= '0;
      buf_rsel   <= '0;
      buf_addr   <= '0;
      win_dly    <= '0;
      end_dly    <= '0;
      frame_done <= 1'b0;
    end else begin
      buf_we     <= pix_ok;
      buf_wsel   <= pix_ok ? conv_pkg::sel_t'(wr_line + 1'b1) : '0;
      buf_rsel   <= rd_go ? conv_pkg::sel_t'(rd_base + 1'b1) : '0;
      buf_addr   <= col;
      win_dly    <= {win_dly[1:0], win_go};   // Matches read and shift stages.
      end_dly    <= {end_dly[1:0], end_go};
      frame_done <= end_dly[2];               // One more stage for the MAC.
    end
  end

  assign win_valid = win_dly[2];

  a_pix_in_frame: assert property (@(posedge clk) disable iff (!xrst)
    pixel_valid |-> (state == conv_pkg::FILL || state == conv_pkg::SWEEP));

  // A row arrives as one unbroken burst.
  a_row_burst: assert property (@(posedge clk) disable iff (!xrst)
    (pix_ok && !col_last) |=> pixel_valid);

endmodule

// ==== source/window_mac.sv ====
`timescale 1ns/1ps

module window_mac (
  input  logic              clk,
  input  logic              xrst,
  input  conv_pkg::kernel_t kernel,
  input  logic              start,
  input  logic              win_valid,
  input  conv_pkg::window_t window,
  output logic              result_valid,
  output conv_pkg::acc_t    result
);

  conv_pkg::kernel_t kern_q;
  conv_pkg::acc_t    prod [conv_pkg::FIL_SIZE*conv_pkg::FIL_SIZE];
  conv_pkg::acc_t    sum;

  // The kernel holds for the whole frame.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      kern_q <= '0;
    end else if (start) begin
      kern_q <= kernel;
    end
  end

  // Operands are sign extended first, so products and sum are exact at ACC_WIDTH.
  always_comb begin
    sum = '0;
    for (int k = 0; k < conv_pkg::FIL_SIZE * conv_pkg::FIL_SIZE; k++) begin
      prod[k] = conv_pkg::acc_t'($signed(window.pix[k]))
              * conv_pkg::acc_t'($signed(kern_q.weight[k]));
      sum = sum + prod[k];
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      result_valid <= 1'b0;
      result       <= '0;
    end else begin
      result_valid <= win_valid;
      if (win_valid) begin
        result <= sum;  // Holds the last result between windows.
      end
    end
  end

endmodule

// ==== source/conv_window_top.sv ====
`timescale 1ns/1ps

module conv_window_top (
  input  logic              clk,
  input  logic              xrst,
  input  logic              start,
  input  conv_pkg::kernel_t kernel,
  input  logic              pixel_valid,
  input  conv_pkg::pixel_t  pixel,
  output logic              result_valid,
  output conv_pkg::acc_t    result,
  output logic              frame_done
);

  conv_pkg::sel_t    buf_wsel;
  conv_pkg::sel_t    buf_rsel;
  logic              buf_we;
  conv_pkg::addr_t   buf_addr;
  logic              win_valid;
  conv_pkg::window_t window;

  linebuf_ctrl u_ctrl (
    .clk         (clk),
    .xrst        (xrst),
    .start       (start),
    .pixel_valid (pixel_valid),
    .buf_wsel    (buf_wsel),
    .buf_rsel    (buf_rsel),
    .buf_we      (buf_we),
    .buf_addr    (buf_addr),
    .win_valid   (win_valid),
    .frame_done  (frame_done)
  );

  // Pixel goes in raw, the line buffer registers it to meet the control.
  line_buffer u_linebuf (
    .clk        (clk),
    .xrst       (xrst),
    .buf_wsel   (buf_wsel),
    .buf_rsel   (buf_rsel),
    .buf_we     (buf_we),
    .buf_addr   (buf_addr),
    .buf_input  (pixel),
    .buf_output (window)
  );

  window_mac u_mac (
    .clk          (clk),
    .xrst         (xrst),
    .kernel       (kernel),
    .start        (start),
    .win_valid    (win_valid),
    .window       (window),
    .result_valid (result_valid),
    .result       (result)
  );

endmodule

// ==== tb/conv_model.svh ====
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// Output side of a valid convolution and the pixel to result latency in cycles.
localparam int OUT_SIZE = conv_pkg::IMG_SIZE - conv_pkg::FIL_SIZE + 1;
localparam int LATENCY  = 4;

longint img [conv_pkg::IMG_SIZE][conv_pkg::IMG_SIZE];
longint kern [conv_pkg::FIL_SIZE][conv_pkg::FIL_SIZE];
int     pix_edge [conv_pkg::IMG_SIZE][conv_pkg::IMG_SIZE];  // Edge that sampled each pixel.

// Expected results in raster order of output positions.
longint exp_val [$];
int     exp_oy [$];
int     exp_ox [$];

function automatic longint window_sum(input int oy, input int ox);
  longint acc;
  acc = 0;
  for (int i = 0; i < conv_pkg::FIL_SIZE; i++) begin
    for (int j = 0; j < conv_pkg::FIL_SIZE; j++) begin
      acc = acc + kern[i][j] * img[oy+i][ox+j];
    end
  end
  return acc;
endfunction

task automatic build_expected();
  exp_val.delete();
  exp_oy.delete();
  exp_ox.delete();
  for (int oy = 0; oy < OUT_SIZE; oy++) begin
    for (int ox = 0; ox < OUT_SIZE; ox++) begin
      exp_val.push_back(window_sum(oy, ox));
      exp_oy.push_back(oy);
      exp_ox.push_back(ox);
    end
  end
endtask

// Output row oy is read while row oy+FIL_SIZE is written, at the window's last column.
// The bottom output row comes from the flush sweep instead.
function automatic int expected_edge(input int oy, input int ox);
  int col;
  int flush_start;
  col = ox + conv_pkg::FIL_SIZE - 1;
  if (oy + conv_pkg::FIL_SIZE < conv_pkg::IMG_SIZE) begin
    return pix_edge[oy+conv_pkg::FIL_SIZE][col] + LATENCY;
  end
  // One idle cycle after the last pixel, then one flush column per cycle.
  flush_start = pix_edge[conv_pkg::IMG_SIZE-1][conv_pkg::IMG_SIZE-1] + 2;
  return flush_start + col + LATENCY;
endfunction

`endif

// ==== tb/tb_conv_window.sv ====
`timescale 1ns/1ps

module tb_conv_window;

  localparam int PERIOD       = 4;
  localparam int NUM_FRAMES   = 6;
  localparam int FRAME_CYCLES = conv_pkg::IMG_SIZE * conv_pkg::IMG_SIZE
                              + 8 * conv_pkg::IMG_SIZE + 50;
  localparam int WATCHDOG_NS  = NUM_FRAMES * FRAME_CYCLES * PERIOD;
  localparam int DONE_WAIT    = 2 * conv_pkg::IMG_SIZE + 20;

  logic              clk;
  logic              xrst;
  logic              start;
  conv_pkg::kernel_t kernel;
  logic              pixel_valid;
  conv_pkg::pixel_t  pixel;
  logic              result_valid;
  conv_pkg::acc_t    result;
  logic              frame_done;

  integer seed;
  int     cyc = 0;            // Rising edges seen so far.
  int     errors;
  int     test_errors;
  int     test_results;
  int     total_results;
  int     results_seen;       // Per frame.
  int     done_seen;
  int     done_edge;

  `include "conv_model.svh"

  conv_window_top u_dut (
    .clk          (clk),
    .xrst         (xrst),
    .start        (start),
    .kernel       (kernel),
    .pixel_valid  (pixel_valid),
    .pixel        (pixel),
    .result_valid (result_valid),
    .result       (result),
    .frame_done   (frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD/2) clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Outputs are sampled mid cycle. The edge that would consume them is cyc+1.
  always @(negedge clk) begin
    if (xrst && result_valid) begin
      check_result();
    end
    if (xrst && frame_done) begin
      done_seen = done_seen + 1;
      done_edge = cyc + 1;
    end
  end

  task automatic check_result();
    longint want;
    int     oy;
    int     ox;
    int     got_edge;
    got_edge = cyc + 1;
    assert (exp_val.size() != 0) else begin
      $display("A result arrived at time %0t when no result was due", $time);
      test_errors++;
    end
    if (exp_val.size() != 0) begin
      want = exp_val.pop_front();
      oy   = exp_oy.pop_front();
      ox   = exp_ox.pop_front();
      results_seen++;
      assert (longint'(result) == want) else begin
        $display("[ERROR] %0t: result at (%0d, %0d) expected %0d got %0d",
                 $time, oy, ox, want, longint'(result));
        test_errors++;
      end
      assert (got_edge == expected_edge(oy, ox)) else begin
        $display("[ERROR] %0t: result at (%0d, %0d) expected at cycle %0d got cycle %0d",
                 $time, oy, ox, expected_edge(oy, ox), got_edge);
        test_errors++;
      end
    end
  endtask

  task automatic fill_ramp();
    for (int r = 0; r < conv_pkg::IMG_SIZE; r++) begin
      for (int x = 0; x < conv_pkg::IMG_SIZE; x++) begin
        img[r][x] = longint'(r * conv_pkg::IMG_SIZE + x);
      end
    end
    for (int i = 0; i < conv_pkg::FIL_SIZE; i++) begin
      for (int j = 0; j < conv_pkg::FIL_SIZE; j++) begin
        kern[i][j] = (i == conv_pkg::FIL_SIZE / 2 && j == conv_pkg::FIL_SIZE / 2) ? 1 : 0;
      end
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < conv_pkg::IMG_SIZE; r++) begin
      for (int x = 0; x < conv_pkg::IMG_SIZE; x++) begin
        img[r][x] = longint'(conv_pkg::pixel_t'($random(seed)));
      end
    end
    for (int i = 0; i < conv_pkg::FIL_SIZE; i++) begin
      for (int j = 0; j < conv_pkg::FIL_SIZE; j++) begin
        kern[i][j] = longint'(conv_pkg::pixel_t'($random(seed)));
      end
    end
  endtask

  task automatic fill_const(input longint pix, input longint weight);
    for (int r = 0; r < conv_pkg::IMG_SIZE; r++) begin
      for (int x = 0; x < conv_pkg::IMG_SIZE; x++) begin
        img[r][x] = pix;
      end
    end
    for (int i = 0; i < conv_pkg::FIL_SIZE; i++) begin
      for (int j = 0; j < conv_pkg::FIL_SIZE; j++) begin
        kern[i][j] = weight;
      end
    end
  endtask

  // The kernel rides on the start pulse, then rows follow as unbroken bursts.
  task automatic drive_frame(input bit gaps);
    int gap;
    for (int i = 0; i < conv_pkg::FIL_SIZE; i++) begin
      for (int j = 0; j < conv_pkg::FIL_SIZE; j++) begin
        kernel.weight[conv_pkg::FIL_SIZE*i+j] = conv_pkg::pixel_t'(kern[i][j]);
      end
    end
    start = 1'b1;
    @(posedge clk);
    #1 start = 1'b0;
    for (int r = 0; r < conv_pkg::IMG_SIZE; r++) begin
      for (int x = 0; x < conv_pkg::IMG_SIZE; x++) begin
        pixel_valid   = 1'b1;
        pixel         = conv_pkg::pixel_t'(img[r][x]);
        pix_edge[r][x] = cyc + 1;  // Sampled at the coming edge.
        @(posedge clk);
        #1;
      end
      pixel_valid = 1'b0;
      gap = gaps ? int'($unsigned($random(seed)) % 6) : 0;
      if (r < conv_pkg::IMG_SIZE - 1) begin
        repeat (gap) begin
          @(posedge clk);
          #1;
        end
      end
    end
  endtask

  task automatic wait_frame_done();
    int waited;
    waited = 0;
    while (done_seen == 0 && waited < DONE_WAIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    assert (done_seen != 0) else begin
      $display("frame_done did not arrive within %0d cycles after the last pixel", DONE_WAIT);
      test_errors++;
    end
  endtask

  task automatic run_frame(input bit gaps);
    results_seen = 0;
    done_seen    = 0;
    done_edge    = 0;
    build_expected();
    drive_frame(gaps);
    wait_frame_done();
    assert (results_seen == OUT_SIZE * OUT_SIZE) else begin
      $display("[ERROR] %0t: result count expected %0d got %0d",
               $time, OUT_SIZE * OUT_SIZE, results_seen);
      test_errors++;
    end
    // frame_done lines up with the result of the last output position.
    assert (done_edge == expected_edge(OUT_SIZE - 1, OUT_SIZE - 1)) else begin
      $display("[ERROR] %0t: frame_done expected at cycle %0d got cycle %0d",
               $time, expected_edge(OUT_SIZE - 1, OUT_SIZE - 1), done_edge);
      test_errors++;
    end
    test_results += results_seen;
  endtask

  // Nothing may follow frame_done until the next start.
  task automatic check_quiet(input int cycles);
    int seen_before;
    seen_before = results_seen;
    repeat (cycles) begin
      @(posedge clk);
      #1;
    end
    assert (results_seen == seen_before && done_seen == 1) else begin
      $display("Output kept coming after the frame: %0d extra results, %0d frame_done pulses",
               results_seen - seen_before, done_seen);
      test_errors++;
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("Test %0d (%s): %0d results, %0d errors", num, name, test_results, test_errors);
    errors        += test_errors;
    total_results += test_results;
    test_errors    = 0;
    test_results   = 0;
  endtask

  initial begin
    seed          = 73;
    errors        = 0;
    test_errors   = 0;
    test_results  = 0;
    total_results = 0;
    done_seen     = 0;
    xrst          = 1'b0;
    start         = 1'b0;
    kernel        = '0;
    pixel_valid   = 1'b0;
    pixel         = '0;
    repeat (3) @(posedge clk);
    #1 xrst = 1'b1;
    @(posedge clk);
    #1;

    fill_ramp();
    run_frame(1'b0);
    report_test(1, "ramp image, identity kernel");

    fill_random();
    run_frame(1'b0);
    report_test(2, "random data, no row gaps");

    fill_random();
    run_frame(1'b1);
    report_test(3, "random data, row gaps, latency");

    fill_random();
    run_frame(1'b1);
    check_quiet(20);
    report_test(4, "result count and framing");

    fill_const(32767, -32768);   // Largest negative sum.
    run_frame(1'b0);
    fill_const(-32768, -32768);  // Largest positive sum.
    run_frame(1'b0);
    report_test(5, "back-to-back extreme frames");

    $display("Summary: 5 tests, %0d results checked, %0d errors", total_results, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("The run did not finish within %0d ns, the DUT or the testbench is hung",
             WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== conv_window.f ====
source/conv_pkg.sv
source/mem_sp.sv
source/line_buffer.sv
source/linebuf_ctrl.sv
source/window_mac.sv
source/conv_window_top.sv
tb/tb_conv_window.sv
+incdir+tb

// ==== Makefile ====
# Verilator build and run for conv_window.

VERILATOR ?= verilator
TOP       ?= tb_conv_window
FILELIST  ?= conv_window.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard tb/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up in the output.
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
